/* run_sim.sh */
#!/bin/sh
# build and run the memory stage testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module tb_mem_top \
    -o sim_mem_top

./obj_dir/sim_mem_top | tee sim.log

# the log decides pass or fail
if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* source/clint_timer.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module clint_timer (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   en_i,
    input  logic                   sel_cmp_i,
    input  logic                   write_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    output logic [`MEM_DATA_W-1:0] rdata_o,
    output logic                   timer_irq_o
);

    logic [`MEM_DATA_W-1:0] mtime_q;
    logic [`MEM_DATA_W-1:0] mtime_d;
    logic [`MEM_DATA_W-1:0] cmp_q;
    logic [`MEM_DATA_W-1:0] cmp_d;
    logic                   wr;

    assign wr = en_i & write_i;

    always_comb begin
        mtime_d = mtime_q + 64'd1;              // free running
        cmp_d   = cmp_q;
        if (wr && !sel_cmp_i) begin
            mtime_d = wdata_i;
        end
        if (wr && sel_cmp_i) begin
            cmp_d = wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            cmp_q       <= '1;                  // no interrupt until programmed
            timer_irq_o <= 1'b0;
        end else begin
            mtime_q     <= mtime_d;
            cmp_q       <= cmp_d;
            timer_irq_o <= mtime_d >= cmp_d;     // tracks the new compare value
        end
    end

    assign rdata_o = sel_cmp_i ? cmp_q : mtime_q;

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr && sel_cmp_i && wdata_i == '1) |=> !timer_irq_o)
        else $error("timer_irq_o set after mtimecmp cleared to all ones");

endmodule

/* source/dcache_array.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module dcache_array (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`DC_IDX_W-1:0]   idx_i,
    output logic [`DC_TAG_W-1:0]   tag_o,
    output logic                   valid_o,
    output logic [`MEM_DATA_W-1:0] data_o,
    input  mem_pipe_pkg::line_wr_t wr_i,
    input  logic                   inv_i
);

    logic [`DC_TAG_W-1:0]   tag_q  [`DC_LINES];
    logic [`MEM_DATA_W-1:0] data_q [`DC_LINES];
    logic [`DC_LINES-1:0]   valid_q;

    // combinational read
    assign tag_o   = tag_q[idx_i];
    assign valid_o = valid_q[idx_i];
    assign data_o  = data_q[idx_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (inv_i) begin
            valid_q <= '0;                      // fence drops every line
        end else if (wr_i.en && wr_i.fill) begin
            valid_q[wr_i.idx] <= 1'b1;
        end
    end

    // a fill carries all strobes, a merge only the stored bytes
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            if (wr_i.fill) begin
                tag_q[wr_i.idx] <= wr_i.tag;
            end
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (wr_i.strb[b]) begin
                    data_q[wr_i.idx][8*b +: 8] <= wr_i.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  mem_pipe_pkg::mem_req_t req_i,
    output logic                   req_ready_o,
    output logic [`MEM_DATA_W-1:0] rdata_o,
    output logic [`DC_IDX_W-1:0]   arr_idx_o,
    input  logic [`DC_TAG_W-1:0]   arr_tag_i,
    input  logic                   arr_valid_i,
    input  logic [`MEM_DATA_W-1:0] arr_data_i,
    output mem_pipe_pkg::line_wr_t arr_wr_o,
    output logic                   arr_inv_o,
    output mem_bus_pkg::apb_req_t  apb_req_o,
    input  mem_bus_pkg::apb_rsp_t  apb_rsp_i,
    output logic [63:0]            cache_hit_o,
    output logic [63:0]            cache_miss_o
);

    mem_bus_pkg::dc_state_e state_q;
    mem_bus_pkg::dc_state_e state_d;
    mem_pipe_pkg::mem_req_t req_q;
    logic                   hit_q;      // lookup result kept for the store merge
    logic [`DC_TAG_W-1:0]   req_tag;
    logic                   hit;
    logic                   is_load;
    logic                   done;
    logic [`MEM_STRB_W-1:0] strb;

    assign req_tag   = req_q.addr[`MEM_ADDR_W-1:`MEM_ADDR_W-`DC_TAG_W];
    assign arr_idx_o = req_q.addr[`DC_IDX_W+2:3];
    assign hit       = arr_valid_i & (arr_tag_i == req_tag);
    assign is_load   = ~req_q.write & ~req_q.fence;
    assign done      = (state_q == mem_bus_pkg::dc_access) & apb_rsp_i.pready;

    always_comb begin
        case (req_q.op)
            mem_pipe_pkg::op_sb: strb = 8'h01 << req_q.addr[2:0];
            mem_pipe_pkg::op_sh: strb = 8'h03 << req_q.addr[2:0];
            mem_pipe_pkg::op_sw: strb = 8'h0f << req_q.addr[2:0];
            default:             strb = 8'hff;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_bus_pkg::dc_idle: begin
                if (req_valid_i) begin
                    state_d = mem_bus_pkg::dc_lookup;
                end
            end
            mem_bus_pkg::dc_lookup: begin
                // fence and load hit finish locally, the rest go out on apb
                if (req_q.fence || (is_load && hit)) begin
                    state_d = mem_bus_pkg::dc_respond;
                end else begin
                    state_d = mem_bus_pkg::dc_setup;
                end
            end
            mem_bus_pkg::dc_setup:  state_d = mem_bus_pkg::dc_access;
            mem_bus_pkg::dc_access: begin
                if (apb_rsp_i.pready) begin
                    state_d = mem_bus_pkg::dc_respond;
                end
            end
            default: state_d = mem_bus_pkg::dc_idle;     // respond
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= mem_bus_pkg::dc_idle;
            hit_q        <= 1'b0;
            cache_hit_o  <= '0;
            cache_miss_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == mem_bus_pkg::dc_lookup) begin
                hit_q <= hit;
                if (is_load && hit) begin
                    cache_hit_o <= cache_hit_o + 64'd1;
                end else if (is_load) begin
                    cache_miss_o <= cache_miss_o + 64'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mem_bus_pkg::dc_idle && req_valid_i) begin
            req_q <= req_i;
        end
    end

    assign arr_inv_o = (state_q == mem_bus_pkg::dc_lookup) & req_q.fence;

    // fill on a load miss, merge on a store hit, in the pready cycle
    always_comb begin
        arr_wr_o.idx  = arr_idx_o;
        arr_wr_o.tag  = req_tag;
        arr_wr_o.data = req_q.write ? req_q.wdata : apb_rsp_i.prdata;
        arr_wr_o.strb = req_q.write ? strb : '1;
        arr_wr_o.fill = ~req_q.write;
        arr_wr_o.en   = done & (~req_q.write | hit_q);
    end

    always_comb begin
        apb_req_o.paddr   = {req_q.addr[`MEM_ADDR_W-1:3], 3'b000};
        apb_req_o.psel    = (state_q == mem_bus_pkg::dc_setup) |
                            (state_q == mem_bus_pkg::dc_access);
        apb_req_o.penable = state_q == mem_bus_pkg::dc_access;
        apb_req_o.pwrite  = req_q.write;
        apb_req_o.pwdata  = req_q.wdata;
        apb_req_o.pstrb   = req_q.write ? strb : '0;
    end

    assign req_ready_o = state_q == mem_bus_pkg::dc_respond;
    assign rdata_o     = arr_data_i;            // line already filled by respond

    assert property (@(posedge clk) disable iff (!rst_n_i)
        apb_req_o.penable |-> apb_req_o.psel)
        else $error("penable without psel");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (apb_req_o.psel && !apb_rsp_i.pready) |=> $stable(apb_req_o.paddr))
        else $error("paddr changed during an apb transfer");

endmodule

/* source/mem_bus_pkg.sv */
`include "mem_params.svh"

package mem_bus_pkg;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`MEM_DATA_W-1:0] pwdata;
        logic [`MEM_STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] prdata;
        logic                   pready;
    } apb_rsp_t;

    typedef enum logic [2:0] {
        dc_idle, dc_lookup, dc_setup, dc_access, dc_respond
    } dc_state_e;

endpackage

/* source/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data path
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_STRB_W 8             // one strobe per byte

// direct-mapped cache, one doubleword per line
`define DC_LINES 16
`define DC_IDX_W 4               // address bits 6:3
`define DC_TAG_W 25              // address bits 31:7

// clint registers
`define CLINT_MTIME_ADDR    32'h0200_0000
`define CLINT_MTIMECMP_ADDR 32'h0200_4000

`endif

/* source/mem_pipe_pkg.sv */
`include "mem_params.svh"

package mem_pipe_pkg;

    // low three bits are func3, bit 3 marks a store
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_ld  = 4'b0011,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_lwu = 4'b0110,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010,
        op_sd  = 4'b1011
    } mem_op_e;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        mem_op_e                op;
        logic                   write;
        logic                   fence;
    } mem_req_t;

    // one array update, either a fill or a byte merge
    typedef struct packed {
        logic [`DC_IDX_W-1:0]   idx;
        logic [`DC_TAG_W-1:0]   tag;
        logic [`MEM_DATA_W-1:0] data;
        logic [`MEM_STRB_W-1:0] strb;
        logic                   fill;   // whole line from memory
        logic                   en;
    } line_wr_t;

endpackage

/* source/mem_stage.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   mem_valid_i,
    input  mem_pipe_pkg::mem_req_t mem_req_i,
    output logic                   mem_ready_o,
    output logic [`MEM_DATA_W-1:0] mem_rdata_o,
    output logic                   dc_valid_o,
    output mem_pipe_pkg::mem_req_t dc_req_o,
    input  logic                   dc_ready_i,
    input  logic [`MEM_DATA_W-1:0] dc_rdata_i,
    output logic                   tmr_en_o,
    output logic                   tmr_sel_cmp_o,
    output logic                   tmr_write_o,
    output logic [`MEM_DATA_W-1:0] tmr_wdata_o,
    input  logic [`MEM_DATA_W-1:0] tmr_rdata_i
);

    logic                   is_mtime;
    logic                   is_cmp;
    logic                   is_tmr;
    logic                   tmr_rdy_q;
    logic [5:0]             lane_sh;
    logic [`MEM_DATA_W-1:0] wdata_sh;
    logic [`MEM_DATA_W-1:0] raw;
    logic [`MEM_DATA_W-1:0] lane;

    // clint decode, a fence always goes to the cache
    assign is_mtime = mem_req_i.addr == `CLINT_MTIME_ADDR;
    assign is_cmp   = mem_req_i.addr == `CLINT_MTIMECMP_ADDR;
    assign is_tmr   = (is_mtime | is_cmp) & ~mem_req_i.fence;

    assign lane_sh  = {mem_req_i.addr[2:0], 3'b000};   // byte offset in bits
    assign wdata_sh = mem_req_i.wdata << lane_sh;

    always_comb begin
        dc_req_o       = mem_req_i;
        dc_req_o.wdata = wdata_sh;      // store data on its byte lane
    end
    assign dc_valid_o = mem_valid_i & ~is_tmr;

    // exactly one timer access per request
    assign tmr_en_o      = mem_valid_i & is_tmr & ~tmr_rdy_q;
    assign tmr_sel_cmp_o = is_cmp;
    assign tmr_write_o   = mem_req_i.write;
    assign tmr_wdata_o   = wdata_sh;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tmr_rdy_q <= 1'b0;
        end else begin
            tmr_rdy_q <= tmr_en_o;
        end
    end

    assign mem_ready_o = tmr_rdy_q | dc_ready_i;

    // pick the addressed lane, then extend
    assign raw  = tmr_rdy_q ? tmr_rdata_i : dc_rdata_i;
    assign lane = raw >> lane_sh;

    always_comb begin
        case (mem_req_i.op)
            mem_pipe_pkg::op_lb:  mem_rdata_o = {{56{lane[7]}}, lane[7:0]};
            mem_pipe_pkg::op_lh:  mem_rdata_o = {{48{lane[15]}}, lane[15:0]};
            mem_pipe_pkg::op_lw:  mem_rdata_o = {{32{lane[31]}}, lane[31:0]};
            mem_pipe_pkg::op_ld:  mem_rdata_o = lane;
            mem_pipe_pkg::op_lbu: mem_rdata_o = {56'b0, lane[7:0]};
            mem_pipe_pkg::op_lhu: mem_rdata_o = {48'b0, lane[15:0]};
            mem_pipe_pkg::op_lwu: mem_rdata_o = {32'b0, lane[31:0]};
            default:              mem_rdata_o = '0;   // stores return nothing
        endcase
    end

    // ready from cache or timer only answers a held request
    assert property (@(posedge clk) disable iff (!rst_n_i) mem_ready_o |-> mem_valid_i)
        else $error("mem_ready_o without mem_valid_i");

endmodule

/* source/mem_top.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   mem_valid_i,
    input  mem_pipe_pkg::mem_req_t mem_req_i,
    output logic                   mem_ready_o,
    output logic [`MEM_DATA_W-1:0] mem_rdata_o,
    output mem_bus_pkg::apb_req_t  apb_req_o,
    input  mem_bus_pkg::apb_rsp_t  apb_rsp_i,
    output logic                   timer_irq_o,
    output logic [63:0]            cache_hit_o,
    output logic [63:0]            cache_miss_o
);

    // stage to cache
    logic                   dc_valid;
    mem_pipe_pkg::mem_req_t dc_req;
    logic                   dc_ready;
    logic [`MEM_DATA_W-1:0] dc_rdata;
    // stage to timer
    logic                   tmr_en;
    logic                   tmr_sel_cmp;
    logic                   tmr_write;
    logic [`MEM_DATA_W-1:0] tmr_wdata;
    logic [`MEM_DATA_W-1:0] tmr_rdata;
    // controller to array
    logic [`DC_IDX_W-1:0]   arr_idx;
    logic [`DC_TAG_W-1:0]   arr_tag;
    logic                   arr_valid;
    logic [`MEM_DATA_W-1:0] arr_data;
    mem_pipe_pkg::line_wr_t arr_wr;
    logic                   arr_inv;

    mem_stage i_stage (
        .clk, .rst_n_i, .mem_valid_i, .mem_req_i, .mem_ready_o, .mem_rdata_o,
        .dc_valid_o    (dc_valid),
        .dc_req_o      (dc_req),
        .dc_ready_i    (dc_ready),
        .dc_rdata_i    (dc_rdata),
        .tmr_en_o      (tmr_en),
        .tmr_sel_cmp_o (tmr_sel_cmp),
        .tmr_write_o   (tmr_write),
        .tmr_wdata_o   (tmr_wdata),
        .tmr_rdata_i   (tmr_rdata)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk, .rst_n_i, .apb_req_o, .apb_rsp_i, .cache_hit_o, .cache_miss_o,
        .req_valid_i (dc_valid),
        .req_i       (dc_req),
        .req_ready_o (dc_ready),
        .rdata_o     (dc_rdata),
        .arr_idx_o   (arr_idx),
        .arr_tag_i   (arr_tag),
        .arr_valid_i (arr_valid),
        .arr_data_i  (arr_data),
        .arr_wr_o    (arr_wr),
        .arr_inv_o   (arr_inv)
    );

    dcache_array i_dcache_array (
        .clk, .rst_n_i,
        .idx_i   (arr_idx),
        .tag_o   (arr_tag),
        .valid_o (arr_valid),
        .data_o  (arr_data),
        .wr_i    (arr_wr),
        .inv_i   (arr_inv)
    );

    clint_timer i_clint_timer (
        .clk, .rst_n_i, .timer_irq_o,
        .en_i      (tmr_en),
        .sel_cmp_i (tmr_sel_cmp),
        .write_i   (tmr_write),
        .wdata_i   (tmr_wdata),
        .rdata_o   (tmr_rdata)
    );

endmodule

/* sources.f */
+incdir+source
source/mem_pipe_pkg.sv
source/mem_bus_pkg.sv
source/mem_stage.sv
source/dcache_ctrl.sv
source/dcache_array.sv
source/clint_timer.sv
source/mem_top.sv
test/tb_clk_gen.sv
test/tb_mem_top.sv

/* test/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;     // 100 ns period
    end

    // reset low for four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* test/tb_mem_top.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module tb_mem_top;

    logic                   clk;
    logic                   rst_n;
    logic                   mem_valid = 1'b0;
    mem_pipe_pkg::mem_req_t mem_req = '0;
    logic                   mem_ready;
    logic [`MEM_DATA_W-1:0] mem_rdata;
    mem_bus_pkg::apb_req_t  apb_req;
    mem_bus_pkg::apb_rsp_t  apb_rsp = '0;
    logic                   timer_irq;
    logic [63:0]            cache_hit;
    logic [63:0]            cache_miss;

    logic [63:0] mem_model [logic [31:0]];   // sparse doubleword memory
    integer      seed = 23665;
    int          wait_left = 0;
    int          apb_reads = 0;
    int          apb_xfers = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    mem_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .mem_valid_i  (mem_valid),
        .mem_req_i    (mem_req),
        .mem_ready_o  (mem_ready),
        .mem_rdata_o  (mem_rdata),
        .apb_req_o    (apb_req),
        .apb_rsp_i    (apb_rsp),
        .timer_irq_o  (timer_irq),
        .cache_hit_o  (cache_hit),
        .cache_miss_o (cache_miss)
    );

    function automatic logic [63:0] fill_pattern(logic [31:0] a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    function automatic logic [63:0] mem_read(logic [31:0] a);
        if (mem_model.exists(a)) return mem_model[a];
        return fill_pattern(a);
    endfunction

    // apb slave answers after 0 to 3 wait cycles
    always @(posedge clk or negedge rst_n) begin : apb_slave
        int          delay;
        logic [63:0] word;
        if (!rst_n) begin
            apb_rsp   <= '0;
            wait_left <= 0;
        end else begin
            apb_rsp.pready <= 1'b0;
            if (apb_req.psel && !apb_req.penable) begin
                apb_xfers = apb_xfers + 1;
                delay     = $random(seed) & 3;      // setup cycle seen
            end else if (apb_req.penable && !apb_rsp.pready) begin
                delay = wait_left - 1;
            end else begin
                delay = -1;
            end
            wait_left <= delay;
            if (delay == 0) begin
                if (apb_req.pwrite) begin
                    word = mem_read(apb_req.paddr);
                    for (int b = 0; b < 8; b++) begin
                        if (apb_req.pstrb[b]) word[8*b +: 8] = apb_req.pwdata[8*b +: 8];
                    end
                    mem_model[apb_req.paddr] = word;
                end else begin
                    apb_reads      = apb_reads + 1;
                    apb_rsp.prdata <= mem_read(apb_req.paddr);
                end
                apb_rsp.pready <= 1'b1;
            end
        end
    end

    task automatic timeout_abort(string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(string name, int start);
        tests++;
        $display("test %s done, %0d errors", name, errors - start);
    endtask

    function automatic int op_size(mem_pipe_pkg::mem_op_e op);
        case (op)
            mem_pipe_pkg::op_lb, mem_pipe_pkg::op_lbu, mem_pipe_pkg::op_sb: return 1;
            mem_pipe_pkg::op_lh, mem_pipe_pkg::op_lhu, mem_pipe_pkg::op_sh: return 2;
            mem_pipe_pkg::op_lw, mem_pipe_pkg::op_lwu, mem_pipe_pkg::op_sw: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic mem_pipe_pkg::mem_op_e load_op(int i);
        case (i)
            0: return mem_pipe_pkg::op_lb;
            1: return mem_pipe_pkg::op_lh;
            2: return mem_pipe_pkg::op_lw;
            3: return mem_pipe_pkg::op_ld;
            4: return mem_pipe_pkg::op_lbu;
            5: return mem_pipe_pkg::op_lhu;
            default: return mem_pipe_pkg::op_lwu;
        endcase
    endfunction

    function automatic mem_pipe_pkg::mem_op_e store_op(int i);
        case (i)
            0: return mem_pipe_pkg::op_sb;
            1: return mem_pipe_pkg::op_sh;
            2: return mem_pipe_pkg::op_sw;
            default: return mem_pipe_pkg::op_sd;
        endcase
    endfunction

    // lane bytes sign filled for the signed loads
    function automatic logic [63:0] expect_load(logic [63:0] dword, int off,
                                                mem_pipe_pkg::mem_op_e op);
        logic [63:0] val;
        int          size;
        logic        sgn;
        size = op_size(op);
        val  = '0;
        for (int j = 0; j < size; j++) val[8*j +: 8] = dword[8*(off+j) +: 8];
        sgn = (op == mem_pipe_pkg::op_lb || op == mem_pipe_pkg::op_lh ||
               op == mem_pipe_pkg::op_lw) && val[8*size-1];
        for (int j = size; j < 8; j++) val[8*j +: 8] = {8{sgn}};
        return val;
    endfunction

    function automatic logic [63:0] merge_store(logic [63:0] line, int off,
                                                mem_pipe_pkg::mem_op_e op, logic [63:0] wd);
        logic [63:0] merged;
        merged = line;
        for (int j = 0; j < op_size(op); j++) merged[8*(off+j) +: 8] = wd[8*j +: 8];
        return merged;
    endfunction

    // one request held until mem_ready_o
    task automatic do_access(input logic [31:0] addr, input logic [63:0] wdata,
                             input mem_pipe_pkg::mem_op_e op, input logic write,
                             input logic fence, output int lat, output logic [63:0] rdata);
        mem_pipe_pkg::mem_req_t req;
        logic                   seen;
        req.addr  = addr;
        req.wdata = wdata;
        req.op    = op;
        req.write = write;
        req.fence = fence;
        lat       = 0;
        seen      = 1'b0;
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_req   <= req;
        while (!seen && lat < 40) begin
            @(negedge clk);
            seen = mem_ready;
            if (!seen) lat++;
        end
        if (!seen) begin
            timeout_abort("mem_ready_o did not rise");
        end else begin
            rdata = mem_rdata;
            @(posedge clk);
            mem_valid <= 1'b0;
        end
    endtask

    task automatic load(input logic [31:0] addr, input mem_pipe_pkg::mem_op_e op,
                        output int lat, output logic [63:0] rdata);
        do_access(addr, 64'h0, op, 1'b0, 1'b0, lat, rdata);
    endtask

    task automatic store(input logic [31:0] addr, input mem_pipe_pkg::mem_op_e op,
                         input logic [63:0] wdata);
        int          lat;
        logic [63:0] rdata;
        do_access(addr, wdata, op, 1'b1, 1'b0, lat, rdata);
    endtask

    task automatic wait_irq(logic level);
        int n;
        n = 0;
        while (timer_irq !== level && n < 3) begin
            @(negedge clk);
            n++;
        end
        compare_value("timer_irq_o", 64'(timer_irq), 64'(level));
    endtask

    task automatic extend_loads();
        logic [31:0]           base;
        logic [63:0]           dword;
        logic [63:0]           rd;
        int                    lat;
        int                    start;
        mem_pipe_pkg::mem_op_e op;
        start = errors;
        dword = {$random(seed), $random(seed)};
        for (int k = 0; k < 2; k++) begin
            base = 32'h0000_1000 + 32'(8 * k);
            mem_model[base] = (k == 0) ? dword : ~dword;   // both sign cases per lane
            for (int i = 0; i < 7; i++) begin
                op = load_op(i);
                for (int off = 0; off < 8; off += op_size(op)) begin
                    load(base + 32'(off), op, lat, rd);
                    compare_value("mem_rdata_o", rd, expect_load(mem_model[base], off, op));
                end
            end
        end
        finish_test("load extension", start);
    endtask

    task automatic count_hits();
        logic [31:0] addr;
        logic [63:0] rd;
        logic [63:0] hits;
        logic [63:0] misses;
        int          lat;
        int          reads;
        int          start;
        start  = errors;
        addr   = 32'h0000_2040;
        hits   = cache_hit;
        misses = cache_miss;
        reads  = apb_reads;
        for (int i = 0; i < 2; i++) begin
            load(addr, mem_pipe_pkg::op_ld, lat, rd);
            compare_value("mem_rdata_o", rd, fill_pattern(addr));
            compare_value("cache_hit_o", cache_hit, hits + 64'(i));
            compare_value("cache_miss_o", cache_miss, misses + 64'd1);
            compare_value("apb read count", 64'(apb_reads), 64'(reads + 1));
        end
        compare_value("load hit latency", 64'(lat), 64'd2);
        finish_test("hit and miss counting", start);
    endtask

    task automatic write_through_stores();
        logic [31:0]           addr;
        logic [63:0]           line;
        logic [63:0]           wd;
        logic [63:0]           rd;
        logic [63:0]           count;
        int                    lat;
        int                    start;
        mem_pipe_pkg::mem_op_e op;
        start = errors;
        addr  = 32'h0000_3018;
        load(addr, mem_pipe_pkg::op_ld, lat, rd);     // bring the line in
        line = mem_read(addr);
        for (int i = 0; i < 4; i++) begin
            op = store_op(i);
            for (int off = 0; off < 8; off += op_size(op)) begin
                wd   = {$random(seed), $random(seed)};
                line = merge_store(line, off, op, wd);
                store(addr + 32'(off), op, wd);
                compare_value("memory word", mem_read(addr), line);
                count = cache_hit;
                load(addr, mem_pipe_pkg::op_ld, lat, rd);
                compare_value("mem_rdata_o", rd, line);
                compare_value("cache_hit_o", cache_hit, count + 64'd1);
            end
        end
        addr = 32'h0000_4028;                           // never cached
        wd   = {$random(seed), $random(seed)};
        store(addr, mem_pipe_pkg::op_sd, wd);
        count = cache_miss;
        load(addr, mem_pipe_pkg::op_ld, lat, rd);
        compare_value("cache_miss_o", cache_miss, count + 64'd1);
        compare_value("mem_rdata_o", rd, wd);
        finish_test("write-through store", start);
    endtask

    task automatic evict_and_fence();
        logic [31:0] addr;
        logic [63:0] rd;
        logic [63:0] count;
        int          lat;
        int          reads;
        int          start;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            addr  = ((i & 1) != 0) ? 32'h0000_50b0 : 32'h0000_5030;   // same index 6
            count = cache_miss;
            reads = apb_reads;
            load(addr, mem_pipe_pkg::op_ld, lat, rd);
            compare_value("mem_rdata_o", rd, mem_read(addr));
            compare_value("cache_miss_o", cache_miss, count + 64'd1);
            compare_value("apb read count", 64'(apb_reads), 64'(reads + 1));
        end
        count = cache_hit;
        load(addr, mem_pipe_pkg::op_ld, lat, rd);
        compare_value("cache_hit_o", cache_hit, count + 64'd1);
        do_access(32'h0, 64'h0, mem_pipe_pkg::op_ld, 1'b0, 1'b1, lat, rd);
        compare_value("fence latency", 64'(lat), 64'd2);
        count = cache_miss;
        load(addr, mem_pipe_pkg::op_ld, lat, rd);
        compare_value("cache_miss_o", cache_miss, count + 64'd1);
        compare_value("mem_rdata_o", rd, mem_read(addr));
        finish_test("conflict and fence", start);
    endtask

    task automatic access_clint();
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] rd;
        int          lat;
        int          xfers;
        int          start;
        start = errors;
        xfers = apb_xfers;
        load(`CLINT_MTIME_ADDR, mem_pipe_pkg::op_ld, lat, t1);
        compare_value("clint latency", 64'(lat), 64'd1);
        load(`CLINT_MTIME_ADDR, mem_pipe_pkg::op_ld, lat, t2);
        checks++;
        if (t2 <= t1) begin
            errors++;
            $display("mtime did not increase between two reads");
        end
        store(`CLINT_MTIMECMP_ADDR, mem_pipe_pkg::op_sd, 64'h1234_5678_9abc_def0);
        load(`CLINT_MTIMECMP_ADDR, mem_pipe_pkg::op_ld, lat, rd);
        compare_value("mtimecmp", rd, 64'h1234_5678_9abc_def0);
        compare_value("timer_irq_o", 64'(timer_irq), 64'd0);
        load(`CLINT_MTIME_ADDR, mem_pipe_pkg::op_ld, lat, t1);
        store(`CLINT_MTIMECMP_ADDR, mem_pipe_pkg::op_sd, t1 - 64'd1);
        wait_irq(1'b1);
        store(`CLINT_MTIMECMP_ADDR, mem_pipe_pkg::op_sd, '1);
        wait_irq(1'b0);
        compare_value("apb transfer count", 64'(apb_xfers), 64'(xfers));
        finish_test("clint", start);
    endtask

    initial begin
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeout_abort("reset was not released");
        end else begin
            extend_loads();
            count_hits();
            write_through_stores();
            evict_and_fence();
            access_clint();
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule
